/* source/imem_pkg.sv */
// Instruction fetch path
// Shared types and codes

package imem_pkg;

  //////////////////////////////////////////////////
  // Address and data
  //////////////////////////////////////////////////

  // Fetch or physical address
  typedef logic [31:0] adr_t;

  // One 32-bit instruction parcel
  typedef logic [31:0] parcel_t;

  //////////////////////////////////////////////////
  // BIU transfer attributes
  //////////////////////////////////////////////////

  // Transfer size code of which only WORD is used
  typedef logic [2:0] biu_size_t;
  localparam biu_size_t WORD = 3'b010;

  // Protection flags OR-ed together
  typedef logic [2:0] biu_prot_t;
  localparam biu_prot_t PROT_INSTRUCTION = 3'b100;
  localparam biu_prot_t PROT_PRIVILEGED  = 3'b001;
  localparam biu_prot_t PROT_USER        = 3'b000;

  // Privilege level
  typedef logic [1:0] prv_t;
  localparam prv_t PRV_U = 2'b00;
  localparam prv_t PRV_M = 2'b11;

  //////////////////////////////////////////////////
  // Queue entry fault codes
  //////////////////////////////////////////////////

  typedef logic [1:0] fault_t;
  // Sent to the BIU
  localparam fault_t FAULT_NONE       = 2'b00;
  // Kept local, never on the bus
  localparam fault_t FAULT_MISALIGNED = 2'b01;
  localparam fault_t FAULT_ACCESS     = 2'b10;

endpackage

/* source/imem_pma_chk.sv */
`timescale 1ns/1ps
// Fetch address attribute check

module imem_pma_chk
  import imem_pkg::*;
#(
  parameter int HAS_RVC = 0,
  parameter int PMA_CNT = 2
)
(
  // Address under test
  input  adr_t               mem_adr_i,

  // Region table
  input  adr_t               pma_base_i  [PMA_CNT],
  input  adr_t               pma_limit_i [PMA_CNT],
  input  logic [PMA_CNT-1:0] pma_exec_i,

  // Check results
  output logic               chk_misaligned_o,
  output logic               chk_access_fault_o
);

  //////////////////////////////////////////////////
  // Alignment
  //////////////////////////////////////////////////

  // Compressed ISA allows halfword parcels
  generate
    if (HAS_RVC != 0)
    begin : g_rvc
      assign chk_misaligned_o = mem_adr_i[0];
    end
    else
    begin : g_norvc
      assign chk_misaligned_o = |mem_adr_i[1:0];
    end
  endgenerate

  //////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////

  logic exec_hit;

  // Any executable region holding the address
  always_comb
  begin
    exec_hit = 1'b0;
    for (int i = 0; i < PMA_CNT; i++)
    begin
      // Inclusive on both ends
      if (pma_exec_i[i] &&
          (mem_adr_i >= pma_base_i[i]) &&
          (mem_adr_i <= pma_limit_i[i]))
      begin
        exec_hit = 1'b1;
      end
    end
  end

  // Misalignment takes priority over access fault
  assign chk_access_fault_o = ~chk_misaligned_o & ~exec_hit;

endmodule

/* source/imem_fetch_issue.sv */
`timescale 1ns/1ps
// Fetch request issuer

module imem_fetch_issue
  import imem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,

  // CPU request side
  input  logic      mem_req_i,
  input  adr_t      mem_adr_i,
  input  logic      mem_flush_i,
  input  prv_t      st_prv_i,
  output logic      mem_ack_o,

  // From the attribute checker
  input  logic      chk_misaligned_i,
  input  logic      chk_access_fault_i,

  // Fetch queue
  input  logic      q_full_i,
  input  logic      q_empty_i,
  output logic      push_o,
  output fault_t    push_fault_o,

  // BIU request
  output logic      biu_stb_o,
  input  logic      biu_stb_ack_i,
  output adr_t      biu_adri_o,
  output biu_size_t biu_size_o,
  output biu_prot_t biu_prot_o
);

  logic chk_fail;
  logic bus_take;
  logic local_take;

  assign chk_fail = chk_misaligned_i | chk_access_fault_i;

  //////////////////////////////////////////////////
  // Bus issue
  //////////////////////////////////////////////////

  // Strobe held while the CPU holds the request
  // Flush blocks issue in its own cycle
  assign biu_stb_o  = mem_req_i & ~chk_fail & ~q_full_i & ~mem_flush_i;
  assign biu_adri_o = mem_adr_i;
  assign biu_size_o = WORD;

  // Accepted once the BIU takes the strobe
  assign bus_take = biu_stb_o & biu_stb_ack_i;

  //////////////////////////////////////////////////
  // Local faults
  //////////////////////////////////////////////////

  // A faulting fetch waits for an empty queue
  // Its entry retires without a bus response, so no response may be
  // due while it sits at the head
  assign local_take = mem_req_i & chk_fail & q_empty_i & ~mem_flush_i;

  //////////////////////////////////////////////////
  // Acceptance and queue push
  //////////////////////////////////////////////////

  // One pulse per accepted address
  assign mem_ack_o = bus_take | local_take;
  assign push_o    = mem_ack_o;

  // Fault code for the pushed entry
  always_comb
  begin
    if (chk_misaligned_i)
      push_fault_o = FAULT_MISALIGNED;
    else if (chk_access_fault_i)
      push_fault_o = FAULT_ACCESS;
    else
      push_fault_o = FAULT_NONE;
  end

  // Protection flags follow privilege a cycle later
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      biu_prot_o <= PROT_INSTRUCTION | PROT_PRIVILEGED;
    else if (st_prv_i == PRV_U)
      biu_prot_o <= PROT_INSTRUCTION | PROT_USER;
    else
      biu_prot_o <= PROT_INSTRUCTION | PROT_PRIVILEGED;
  end

endmodule

/* source/imem_fetch_queue.sv */
`timescale 1ns/1ps
// Outstanding fetch queue

module imem_fetch_queue
  import imem_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
)
(
  input  logic   clk_i,
  input  logic   rst_i,

  // Write side
  input  logic   push_i,
  input  fault_t push_fault_i,

  // Read side
  input  logic   pop_i,
  input  logic   flush_i,

  // Status
  output logic   full_o,
  output logic   empty_o,
  output fault_t head_fault_o,
  output logic   head_stale_o
);

  // Pointers wrap on their own for a power of two depth
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // Entry storage
  fault_t fault_mem [QUEUE_DEPTH];
  logic   stale_mem [QUEUE_DEPTH];

  //////////////////////////////////////////////////
  // Pointers and occupancy
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;

      // Simultaneous push and pop leaves count alone
      if (push_i && !pop_i)
        count <= count + 1'b1;
      else if (pop_i && !push_i)
        count <= count - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Entry storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    // Flush marks every slot stale
    if (flush_i)
    begin
      for (int i = 0; i < QUEUE_DEPTH; i++)
        stale_mem[i] <= 1'b1;
    end

    // New entry is fresh unless it lands with a flush
    if (push_i)
    begin
      fault_mem[wr_ptr] <= push_fault_i;
      stale_mem[wr_ptr] <= flush_i;
    end
  end

  // Head and status from registered state
  assign head_fault_o = fault_mem[rd_ptr];
  assign head_stale_o = stale_mem[rd_ptr];
  assign empty_o      = (count == '0);
  assign full_o       = (count == (PTR_W+1)'(QUEUE_DEPTH));

endmodule

/* source/imem_parcel_return.sv */
`timescale 1ns/1ps
// Parcel return stage

module imem_parcel_return
  import imem_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,

  // Queue head
  input  logic    q_empty_i,
  input  fault_t  q_head_fault_i,
  input  logic    q_head_stale_i,
  output logic    q_pop_o,

  // BIU response
  input  logic    biu_ack_i,
  input  logic    biu_err_i,
  input  parcel_t biu_q_i,

  // CPU parcel
  output parcel_t parcel_o,
  output logic    parcel_valid_o,
  output logic    mem_error_o,
  output logic    mem_misaligned_o
);

  logic head_bus;
  logic bus_rsp;
  logic deliver;
  logic err_nxt;
  logic mis_nxt;

  //////////////////////////////////////////////////
  // Head retire
  //////////////////////////////////////////////////

  // Head went out on the bus
  assign head_bus = (q_head_fault_i == FAULT_NONE);
  assign bus_rsp  = biu_ack_i | biu_err_i;

  // Bus entries wait for their response
  // Faulted entries leave right away
  assign q_pop_o = ~q_empty_i & (head_bus ? bus_rsp : 1'b1);

  // Flushed entries retire silently
  assign deliver = q_pop_o & ~q_head_stale_i;

  //////////////////////////////////////////////////
  // Flags for the retiring entry
  //////////////////////////////////////////////////

  // Bus error or local access fault
  assign err_nxt = head_bus ? biu_err_i : (q_head_fault_i == FAULT_ACCESS);
  assign mis_nxt = (q_head_fault_i == FAULT_MISALIGNED);

  //////////////////////////////////////////////////
  // CPU output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      parcel_valid_o   <= 1'b0;
      mem_error_o      <= 1'b0;
      mem_misaligned_o <= 1'b0;
    end
    else
    begin
      // Single cycle strobe per parcel
      parcel_valid_o   <= deliver;
      mem_error_o      <= deliver & err_nxt;
      mem_misaligned_o <= deliver & mis_nxt;
    end
  end

  // Parcel data only from the bus
  always_ff @(posedge clk_i)
  begin
    if (deliver && head_bus)
      parcel_o <= biu_q_i;
  end

endmodule

/* source/imem_ctrl.sv */
`timescale 1ns/1ps
// Uncached instruction fetch access

module imem_ctrl
  import imem_pkg::*;
#(
  parameter int HAS_RVC     = 0,
  parameter int PMA_CNT     = 2,
  parameter int QUEUE_DEPTH = 4
)
(
  input  logic               clk_i,
  input  logic               rst_i,

  // Region table
  input  adr_t               pma_base_i  [PMA_CNT],
  input  adr_t               pma_limit_i [PMA_CNT],
  input  logic [PMA_CNT-1:0] pma_exec_i,

  // Privilege
  input  prv_t               st_prv_i,

  // CPU side
  input  logic               mem_req_i,
  input  adr_t               mem_adr_i,
  input  logic               mem_flush_i,
  output logic               mem_ack_o,
  output parcel_t            parcel_o,
  output logic               parcel_valid_o,
  output logic               mem_error_o,
  output logic               mem_misaligned_o,

  // BIU side
  output logic               biu_stb_o,
  input  logic               biu_stb_ack_i,
  output adr_t               biu_adri_o,
  output biu_size_t          biu_size_o,
  output biu_prot_t          biu_prot_o,
  input  parcel_t            biu_q_i,
  input  logic               biu_ack_i,
  input  logic               biu_err_i
);

  //////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////

  // Checker to issuer
  logic   chk_misaligned;
  logic   chk_access_fault;

  // Issuer to queue
  logic   push;
  fault_t push_fault;

  // Queue status and head
  logic   q_full;
  logic   q_empty;
  fault_t q_head_fault;
  logic   q_head_stale;
  logic   q_pop;

  //////////////////////////////////////////////////
  // Attribute check
  //////////////////////////////////////////////////

  imem_pma_chk #(
    .HAS_RVC            ( HAS_RVC          ),
    .PMA_CNT            ( PMA_CNT          )
  )
  u_pma_chk (
    .mem_adr_i          ( mem_adr_i        ),
    .pma_base_i         ( pma_base_i       ),
    .pma_limit_i        ( pma_limit_i      ),
    .pma_exec_i         ( pma_exec_i       ),
    .chk_misaligned_o   ( chk_misaligned   ),
    .chk_access_fault_o ( chk_access_fault )
  );

  //////////////////////////////////////////////////
  // Request issue
  //////////////////////////////////////////////////

  imem_fetch_issue u_fetch_issue (
    .clk_i              ( clk_i            ),
    .rst_i              ( rst_i            ),
    .mem_req_i          ( mem_req_i        ),
    .mem_adr_i          ( mem_adr_i        ),
    .mem_flush_i        ( mem_flush_i      ),
    .st_prv_i           ( st_prv_i         ),
    .mem_ack_o          ( mem_ack_o        ),
    .chk_misaligned_i   ( chk_misaligned   ),
    .chk_access_fault_i ( chk_access_fault ),
    .q_full_i           ( q_full           ),
    .q_empty_i          ( q_empty          ),
    .push_o             ( push             ),
    .push_fault_o       ( push_fault       ),
    .biu_stb_o          ( biu_stb_o        ),
    .biu_stb_ack_i      ( biu_stb_ack_i    ),
    .biu_adri_o         ( biu_adri_o       ),
    .biu_size_o         ( biu_size_o       ),
    .biu_prot_o         ( biu_prot_o       )
  );

  //////////////////////////////////////////////////
  // In-flight queue
  //////////////////////////////////////////////////

  // Flush goes here and to the issuer
  imem_fetch_queue #(
    .QUEUE_DEPTH        ( QUEUE_DEPTH      )
  )
  u_fetch_queue (
    .clk_i              ( clk_i            ),
    .rst_i              ( rst_i            ),
    .push_i             ( push             ),
    .push_fault_i       ( push_fault       ),
    .pop_i              ( q_pop            ),
    .flush_i            ( mem_flush_i      ),
    .full_o             ( q_full           ),
    .empty_o            ( q_empty          ),
    .head_fault_o       ( q_head_fault     ),
    .head_stale_o       ( q_head_stale     )
  );

  //////////////////////////////////////////////////
  // Parcel return
  //////////////////////////////////////////////////

  imem_parcel_return u_parcel_return (
    .clk_i              ( clk_i            ),
    .rst_i              ( rst_i            ),
    .q_empty_i          ( q_empty          ),
    .q_head_fault_i     ( q_head_fault     ),
    .q_head_stale_i     ( q_head_stale     ),
    .q_pop_o            ( q_pop            ),
    .biu_ack_i          ( biu_ack_i        ),
    .biu_err_i          ( biu_err_i        ),
    .biu_q_i            ( biu_q_i          ),
    .parcel_o           ( parcel_o         ),
    .parcel_valid_o     ( parcel_valid_o   ),
    .mem_error_o        ( mem_error_o      ),
    .mem_misaligned_o   ( mem_misaligned_o )
  );

endmodule

/* tb/imem_biu_model.sv */
`timescale 1ns/1ps
// Behavioral BIU for fetch tests

module imem_biu_model
#(
  parameter logic [31:0] SEED     = 32'h9f56_7ff3,
  parameter logic [31:0] DATA_PAT = 32'hA5A5_0000,
  parameter logic [31:0] ERR_LO   = 32'h0000_0800,
  parameter logic [31:0] ERR_HI   = 32'h0000_083F
)
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        slow_i,
  input  logic        biu_stb_i,
  input  logic [31:0] biu_adri_i,
  output logic        biu_stb_ack_o,
  output logic [31:0] biu_q_o,
  output logic        biu_ack_o,
  output logic        biu_err_o
);

  // Accepted transfers in order of acceptance
  logic [31:0] pend_adr [$];
  int          pend_due [$];

  initial
  begin : bus_proc
    logic [31:0] adr;
    logic        rsp_ack;
    logic        rsp_err;
    logic [31:0] rsp_q;
    logic        take_nxt;
    int          lat;
    int          cyc;
    // Every draw comes from this one process
    void'($urandom(SEED));
    cyc           = 0;
    biu_stb_ack_o = 1'b0;
    biu_q_o       = '0;
    biu_ack_o     = 1'b0;
    biu_err_o     = 1'b0;
    forever
    begin
      @(posedge clk_i);
      cyc++;
      rsp_ack  = 1'b0;
      rsp_err  = 1'b0;
      rsp_q    = '0;
      take_nxt = 1'b0;
      if (rst_i)
      begin
        pend_adr.delete();
        pend_due.delete();
      end
      else
      begin
        // Oldest transfer answers once its latency is over
        if (pend_adr.size() != 0 && pend_due[0] <= cyc)
        begin
          adr = pend_adr.pop_front();
          void'(pend_due.pop_front());
          rsp_q = adr ^ DATA_PAT;
          if (adr >= ERR_LO && adr <= ERR_HI)
            rsp_err = 1'b1;
          else
            rsp_ack = 1'b1;
        end
        // Strobe taken on this edge
        if (biu_stb_i && biu_stb_ack_o)
        begin
          lat = slow_i ? 4 + $urandom % 4 : 1 + $urandom % 3;
          pend_adr.push_back(biu_adri_i);
          pend_due.push_back(cyc + lat);
        end
        // Slow mode stalls the strobe ack more often
        take_nxt = slow_i ? ($urandom % 2 == 0) : ($urandom % 4 != 0);
      end
      #1;
      biu_stb_ack_o = take_nxt;
      biu_ack_o     = rsp_ack;
      biu_err_o     = rsp_err;
      biu_q_o       = rsp_q;
    end
  end

endmodule

/* tb/imem_ctrl_tb.sv */
`timescale 1ns/1ps
// Fetch access testbench

module imem_ctrl_tb
  import imem_pkg::*;
();

  localparam int          PMA_CNT     = 2;
  localparam int          QUEUE_DEPTH = 4;
  localparam logic [31:0] SEED        = 32'h9f56_7ff3;
  localparam logic [31:0] DATA_PAT    = 32'hA5A5_0000;
  localparam logic [31:0] EXEC_HI     = 32'h0000_0FFF;
  localparam logic [31:0] ERR_LO      = 32'h0000_0800;
  localparam logic [31:0] ERR_HI      = 32'h0000_083F;
  // About 60 fetches, under 15 cycles each even when slow, plus drains
  localparam int          TIMEOUT_CYC = 2000;

  logic clk = 1'b0;
  logic rst;
  adr_t pma_base  [PMA_CNT];
  adr_t pma_limit [PMA_CNT];
  logic [PMA_CNT-1:0] pma_exec;
  prv_t st_prv;
  logic mem_req, mem_flush, mem_ack, slow;
  adr_t mem_adr;
  parcel_t parcel, biu_q;
  logic parcel_valid, mem_error, mem_misaligned;
  logic biu_stb, biu_stb_ack, biu_ack, biu_err;
  adr_t biu_adri;
  biu_size_t biu_size;
  biu_prot_t biu_prot;

  // Scoreboard in acceptance order
  logic [31:0] sb_adr [$];
  logic        sb_err [$];
  logic        sb_mis [$];
  int stale_cnt = 0;
  int drop_cnt = 0;
  int rx_cnt = 0;
  int inflight = 0;
  int cyc_cnt = 0;
  int fail_cnt = 0;

  // Privilege seen a cycle earlier
  prv_t prv_q = PRV_M;

  always #2 clk = ~clk;

  imem_ctrl #(.HAS_RVC(0), .PMA_CNT(PMA_CNT), .QUEUE_DEPTH(QUEUE_DEPTH)) DUT (
    .clk_i(clk), .rst_i(rst),
    .pma_base_i(pma_base), .pma_limit_i(pma_limit), .pma_exec_i(pma_exec),
    .st_prv_i(st_prv), .mem_req_i(mem_req), .mem_adr_i(mem_adr), .mem_flush_i(mem_flush),
    .mem_ack_o(mem_ack), .parcel_o(parcel), .parcel_valid_o(parcel_valid),
    .mem_error_o(mem_error), .mem_misaligned_o(mem_misaligned),
    .biu_stb_o(biu_stb), .biu_stb_ack_i(biu_stb_ack), .biu_adri_o(biu_adri),
    .biu_size_o(biu_size), .biu_prot_o(biu_prot), .biu_q_i(biu_q),
    .biu_ack_i(biu_ack), .biu_err_i(biu_err)
  );

  imem_biu_model #(.SEED(SEED), .DATA_PAT(DATA_PAT), .ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_biu (
    .clk_i(clk), .rst_i(rst), .slow_i(slow), .biu_stb_i(biu_stb), .biu_adri_i(biu_adri),
    .biu_stb_ack_o(biu_stb_ack), .biu_q_o(biu_q), .biu_ack_o(biu_ack), .biu_err_o(biu_err)
  );

  //////////////////////////////////////////////////
  // Address rules and error reporting
  //////////////////////////////////////////////////

  function automatic logic is_misaligned(input logic [31:0] adr);
    return adr[1:0] != 2'b00;
  endfunction

  // Only region 0 executes
  function automatic logic is_local(input logic [31:0] adr);
    return is_misaligned(adr) || (adr > EXEC_HI);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    fail_cnt++;
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_val, got_val);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_problem(input string msg);
    fail_cnt++;
    $display("[FAIL] %0t ns %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////
  // Monitor sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin : monitor
    logic [31:0] exp_adr;
    logic        exp_err;
    logic        exp_mis;
    logic        resp;
    logic        stale_hit;
    biu_prot_t   exp_prot;
    int          keep;
    if (!rst)
    begin
      resp      = biu_ack | biu_err;
      // Response on a flushed head retires it silently
      stale_hit = resp && (stale_cnt != 0);
      if (parcel_valid)
      begin
        assert (sb_adr.size() != 0)
        else report_problem("parcel returned with no fetch outstanding");
        exp_adr = sb_adr.pop_front();
        exp_err = sb_err.pop_front();
        exp_mis = sb_mis.pop_front();
        rx_cnt++;
        assert (mem_error == exp_err) else report_mismatch("mem_error_o", exp_err, mem_error);
        assert (mem_misaligned == exp_mis)
        else report_mismatch("mem_misaligned_o", exp_mis, mem_misaligned);
        if (!is_local(exp_adr))
        begin
          assert (parcel == (exp_adr ^ DATA_PAT))
          else report_mismatch("parcel_o", exp_adr ^ DATA_PAT, parcel);
        end
      end
      else
      begin
        assert (!mem_error && !mem_misaligned)
        else report_problem("error flag set without a parcel");
      end
      // Strobe only for good addresses
      if (biu_stb)
      begin
        assert (!is_local(mem_adr)) else report_problem("strobe raised for a faulting address");
        assert (!mem_flush) else report_problem("strobe raised during a flush");
        assert (biu_adri == mem_adr) else report_mismatch("biu_adri_o", mem_adr, biu_adri);
        assert (biu_size == WORD) else report_mismatch("biu_size_o", WORD, biu_size);
        // Machine mode is privileged, user mode is not
        if (prv_q == PRV_M)
          exp_prot = PROT_INSTRUCTION | PROT_PRIVILEGED;
        else
          exp_prot = PROT_INSTRUCTION | PROT_USER;
        assert (biu_prot == exp_prot)
        else report_mismatch("biu_prot_o", exp_prot, biu_prot);
      end
      if (mem_flush)
      begin
        assert (!mem_ack) else report_problem("fetch accepted during a flush");
        // A head that retires on this edge still delivers
        keep = 0;
        if (sb_adr.size() != 0 && !stale_hit && (resp || is_local(sb_adr[0])))
          keep = 1;
        while (sb_adr.size() > keep)
        begin
          sb_adr.delete(sb_adr.size() - 1);
          sb_err.delete(sb_err.size() - 1);
          sb_mis.delete(sb_mis.size() - 1);
          stale_cnt++;
          drop_cnt++;
        end
      end
      if (stale_hit)
        stale_cnt--;
      if (mem_ack)
      begin
        sb_adr.push_back(mem_adr);
        sb_mis.push_back(is_misaligned(mem_adr));
        sb_err.push_back(!is_misaligned(mem_adr) &&
                         (mem_adr > EXEC_HI || (mem_adr >= ERR_LO && mem_adr <= ERR_HI)));
      end
      // Bus transfers not yet answered
      if (biu_stb && biu_stb_ack)
        inflight++;
      if (resp)
        inflight--;
      assert (inflight <= QUEUE_DEPTH)
      else report_problem("more fetches outstanding than the queue holds");
    end
    // Protection flags lag privilege by one edge
    prv_q = st_prv;
  end

  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT_CYC)
    begin
      $display("Timeout after %0d cycles, fetches never completed", cyc_cnt);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  //////////////////////////////////////////////////
  // Drive helpers
  //////////////////////////////////////////////////

  // Holds the request until accepted, returns 1 ns after the edge
  task automatic fetch_one(input logic [31:0] adr);
    mem_req = 1'b1;
    mem_adr = adr;
    do
      @(negedge clk);
    while (!mem_ack);
    @(posedge clk);
    #1;
  endtask

  task automatic fetch_run(input logic [31:0] start, input int n);
    for (int i = 0; i < n; i++)
      fetch_one(start + 32'(4 * i));
    mem_req = 1'b0;
  endtask

  // Scoreboard state is settled by the rising edge
  task automatic wait_drain();
    @(posedge clk);
    while (sb_adr.size() != 0 || stale_cnt != 0 || inflight != 0)
      @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic check_after_reset();
    @(negedge clk);
    assert (!biu_stb) else report_mismatch("biu_stb_o", 0, biu_stb);
    assert (!mem_ack) else report_mismatch("mem_ack_o", 0, mem_ack);
    assert (!parcel_valid) else report_mismatch("parcel_valid_o", 0, parcel_valid);
    assert (!mem_error) else report_mismatch("mem_error_o", 0, mem_error);
    assert (!mem_misaligned) else report_mismatch("mem_misaligned_o", 0, mem_misaligned);
    @(posedge clk);
    #1;
  endtask

  task automatic sequential_fetches();
    int rx0;
    rx0 = rx_cnt;
    fetch_run(32'h0000_0100, 16);
    wait_drain();
    assert (rx_cnt - rx0 == 16) else report_mismatch("parcel count", 16, rx_cnt - rx0);
  endtask

  // Local faults interleaved with bus fetches
  task automatic local_fault_mix();
    logic [31:0] adrs [8];
    int          rx0;
    adrs = '{32'h200, 32'h202, 32'h204, 32'h1004, 32'h208, 32'h2001, 32'h20C, 32'h8000};
    rx0  = rx_cnt;
    // User mode fetches
    st_prv = PRV_U;
    foreach (adrs[i])
      fetch_one(adrs[i]);
    mem_req = 1'b0;
    wait_drain();
    st_prv = PRV_M;
    assert (rx_cnt - rx0 == 8) else report_mismatch("parcel count", 8, rx_cnt - rx0);
  endtask

  task automatic error_window_fetches();
    int rx0;
    rx0 = rx_cnt;
    fetch_run(ERR_LO - 32'h8, 6);
    fetch_run(ERR_HI - 32'h3, 2);
    wait_drain();
    assert (rx_cnt - rx0 == 8) else report_mismatch("parcel count", 8, rx_cnt - rx0);
  endtask

  task automatic flush_in_flight();
    int rx0;
    int drop0;
    rx0   = rx_cnt;
    drop0 = drop_cnt;
    fetch_run(32'h0000_0300, 4);
    // Last fetch cannot have been answered yet
    mem_flush = 1'b1;
    @(posedge clk);
    #1;
    mem_flush = 1'b0;
    fetch_run(32'h0000_0400, 4);
    wait_drain();
    assert (rx_cnt - rx0 + drop_cnt - drop0 == 8)
    else report_mismatch("parcels plus drops", 8, rx_cnt - rx0 + drop_cnt - drop0);
  endtask

  task automatic stall_stress();
    int rx0;
    rx0  = rx_cnt;
    slow = 1'b1;
    fetch_run(32'h0000_0500, 24);
    wait_drain();
    slow = 1'b0;
    assert (rx_cnt - rx0 == 24) else report_mismatch("parcel count", 24, rx_cnt - rx0);
  endtask

  initial
  begin
    rst          = 1'b1;
    mem_req      = 1'b0;
    mem_adr      = '0;
    mem_flush    = 1'b0;
    slow         = 1'b0;
    st_prv       = PRV_M;
    pma_base[0]  = 32'h0000_0000;
    pma_limit[0] = EXEC_HI;
    pma_base[1]  = 32'h0000_1000;
    pma_limit[1] = 32'h0000_1FFF;
    pma_exec     = 2'b01;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    check_after_reset();
    sequential_fetches();
    local_fault_mix();
    error_window_fetches();
    flush_in_flight();
    stall_stress();
    if (fail_cnt == 0)
    begin
      $display("All tests passed!");
    end
    else
    begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* flist.f */
source/imem_pkg.sv
source/imem_pma_chk.sv
source/imem_fetch_issue.sv
source/imem_fetch_queue.sv
source/imem_parcel_return.sv
source/imem_ctrl.sv
tb/imem_biu_model.sv
tb/imem_ctrl_tb.sv
